// ==== dispatch_pkg.sv ====
package dispatch_pkg;

    localparam int WORD_W = 32;
    localparam int S_REGS = 32;
    localparam int M_REGS = 16;

    // functional unit latencies in cycles
    localparam int LAT_ALU    = 1;
    localparam int LAT_LDST   = 2;
    localparam int LAT_BRANCH = 1;
    localparam int LAT_MLDST  = 4;
    localparam int LAT_GEMM   = 8;

    typedef logic [4:0] regbits_t;
    typedef logic [3:0] matbits_t;
    typedef logic [1:0] tag_t;

    // register status tags, exec covers both ALU and GEMM producers
    localparam tag_t TAG_NONE = 2'd0;
    localparam tag_t TAG_EXEC = 2'd1;
    localparam tag_t TAG_LOAD = 2'd2;

    typedef enum logic [6:0] {
        OP_NOP    = 7'h00,
        OP_ALU    = 7'h33,
        OP_ALUI   = 7'h13,
        OP_LOAD   = 7'h03,
        OP_STORE  = 7'h23,
        OP_BRANCH = 7'h63,
        OP_MLOAD  = 7'h07,
        OP_MSTORE = 7'h27,
        OP_GEMM   = 7'h77
    } opcode_t;

    typedef enum logic [1:0] {FU_NONE_T, FU_S_T, FU_M_T, FU_G_T} fu_type_t;
    typedef enum logic [1:0] {FU_S_ALU, FU_S_LD_ST, FU_S_BRANCH} fu_s_t;
    typedef enum logic {FU_M_LD_ST, FU_M_GEMM} fu_m_t;

    // ordered so that funct3 maps straight onto the op, sub taken from bit 30
    typedef enum logic [2:0] {
        ALU_ADD, ALU_SLL, ALU_SLT, ALU_SUB, ALU_XOR, ALU_SRL, ALU_OR, ALU_AND
    } alu_op_t;

    typedef enum logic [1:0] {NONE, LOAD, STORE} mem_type_t;

    typedef struct packed {
        fu_type_t    fu_t;
        fu_s_t       fu_s;
        fu_m_t       fu_m;
        logic [11:0] imm;
        alu_op_t     alu_op;
        logic [2:0]  branch_op;
        mem_type_t   s_mem_type;
        mem_type_t   m_mem_type;
        logic        s_reg_write;
        logic        m_reg_write;
    } cu_t;

    typedef struct packed {
        regbits_t    rd;
        regbits_t    rs1;
        regbits_t    rs2;
        logic [11:0] imm;
        tag_t        t1;
        tag_t        t2;
    } fust_s_t;

    // matrix load/store takes its address operands from scalar registers
    typedef struct packed {
        matbits_t    rd;
        regbits_t    rs1;
        regbits_t    rs2;
        logic [10:0] imm;
        tag_t        t1;
        tag_t        t2;
    } fust_m_t;

    typedef struct packed {
        matbits_t rd;
        matbits_t ms1;
        matbits_t ms2;
        matbits_t ms3;
        tag_t     t1;
        tag_t     t2;
        tag_t     t3;
    } fust_g_t;

    // matrix writebacks use the low 4 bits of rw
    typedef struct packed {
        logic     rw_en;
        regbits_t rw;
    } wb_t;

    typedef struct packed {
        logic [11:0] imm;
        alu_op_t     alu_op;
        logic [2:0]  branch_op;
        mem_type_t   s_mem_type;
        mem_type_t   m_mem_type;
        matbits_t    m_rw;
        logic        m_rw_en;
    } ex_ctr_t;

    typedef struct packed {
        fu_s_t   fu_s;
        fu_m_t   fu_m;
        ex_ctr_t ex_ctr;
        wb_t     wb_ctr;
    } dispatch_t;

    typedef struct packed {
        logic busy;
        tag_t tag;
    } rst_entry_t;

endpackage

// ==== control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
    input  logic [dispatch_pkg::WORD_W-1:0] instr,
    output dispatch_pkg::cu_t               cu
);

    dispatch_pkg::opcode_t opcode;
    logic [2:0]  funct3;
    logic [11:0] i_imm;
    logic [11:0] s_imm;
    logic [11:0] b_imm;
    logic [11:0] m_imm;

    assign opcode = dispatch_pkg::opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];

    // immediate formats
    assign i_imm = instr[31:20];
    assign s_imm = {instr[31:25], instr[11:7]};
    assign b_imm = {instr[31], instr[7], instr[30:25], instr[11:8]};
    // matrix offset lives in the bits left free around the register fields
    assign m_imm = {instr[27], instr[27:25], instr[14:7]};

    always_comb begin
        cu = '0;
        case (opcode)
            dispatch_pkg::OP_ALU, dispatch_pkg::OP_ALUI: begin
                cu.fu_t        = dispatch_pkg::FU_S_T;
                cu.fu_s        = dispatch_pkg::FU_S_ALU;
                cu.alu_op      = dispatch_pkg::alu_op_t'(funct3);
                cu.s_reg_write = 1'b1;
                if (opcode == dispatch_pkg::OP_ALUI) begin
                    cu.imm = i_imm;
                end else if (funct3 == 3'd0 && instr[30]) begin
                    cu.alu_op = dispatch_pkg::ALU_SUB;
                end
            end
            dispatch_pkg::OP_LOAD, dispatch_pkg::OP_STORE: begin
                cu.fu_t = dispatch_pkg::FU_S_T;
                cu.fu_s = dispatch_pkg::FU_S_LD_ST;
                if (opcode == dispatch_pkg::OP_LOAD) begin
                    cu.imm         = i_imm;
                    cu.s_mem_type  = dispatch_pkg::LOAD;
                    cu.s_reg_write = 1'b1;
                end else begin
                    cu.imm        = s_imm;
                    cu.s_mem_type = dispatch_pkg::STORE;
                end
            end
            dispatch_pkg::OP_BRANCH: begin
                cu.fu_t      = dispatch_pkg::FU_S_T;
                cu.fu_s      = dispatch_pkg::FU_S_BRANCH;
                cu.imm       = b_imm;
                cu.alu_op    = dispatch_pkg::ALU_SUB;
                cu.branch_op = funct3;
            end
            dispatch_pkg::OP_MLOAD, dispatch_pkg::OP_MSTORE: begin
                cu.fu_t = dispatch_pkg::FU_M_T;
                cu.fu_m = dispatch_pkg::FU_M_LD_ST;
                cu.imm  = m_imm;
                if (opcode == dispatch_pkg::OP_MLOAD) begin
                    cu.m_mem_type  = dispatch_pkg::LOAD;
                    cu.m_reg_write = 1'b1;
                end else begin
                    cu.m_mem_type = dispatch_pkg::STORE;
                end
            end
            dispatch_pkg::OP_GEMM: begin
                cu.fu_t        = dispatch_pkg::FU_G_T;
                cu.fu_m        = dispatch_pkg::FU_M_GEMM;
                cu.m_reg_write = 1'b1;
            end
            // NOP and unknown opcodes go nowhere
            default: cu = '0;
        endcase
    end

endmodule

// ==== reg_status_table.sv ====
`timescale 1ns/1ps

module reg_status_table #(
    parameter int NREGS = 32
) (
    input  logic                                  CLK,
    input  logic                                  nRST,
    input  logic                                  di_write,
    input  logic [$clog2(NREGS)-1:0]              di_sel,
    input  dispatch_pkg::tag_t                    di_tag,
    input  dispatch_pkg::wb_t                     wb_a,
    input  dispatch_pkg::wb_t                     wb_b,
    output dispatch_pkg::rst_entry_t [NREGS-1:0] status
);

    // a dispatch write never hits a register being cleared, WAW holds it back
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            status <= '0;
        end else begin
            if (wb_a.rw_en) begin
                status[wb_a.rw[$clog2(NREGS)-1:0]] <= '0;
            end
            if (wb_b.rw_en) begin
                status[wb_b.rw[$clog2(NREGS)-1:0]] <= '0;
            end
            if (di_write) begin
                status[di_sel].busy <= 1'b1;
                status[di_sel].tag  <= di_tag;
            end
        end
    end

endmodule

// ==== fu_timer.sv ====
`timescale 1ns/1ps

module fu_timer #(
    parameter int LATENCY = 1
) (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              start,
    input  dispatch_pkg::wb_t start_wb,
    output logic              busy,
    output dispatch_pkg::wb_t wb
);

    logic [$clog2(LATENCY+1)-1:0] count;
    logic                         last;
    dispatch_pkg::wb_t            dest;

    // start only arrives while idle, dispatch treats busy as a structural hazard
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            count <= '0;
        end else if (start) begin
            count <= $bits(count)'(LATENCY);
        end else if (busy) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (start) begin
            dest <= start_wb;
        end
    end

    assign busy = (count != '0);
    assign last = (count == $bits(count)'(1));

    // writeback in the final busy cycle, rw_en only if the op writes a register
    always_comb begin
        wb = '0;
        if (last) begin
            wb = dest;
        end
    end

endmodule

// ==== dispatch.sv ====
`timescale 1ns/1ps

module dispatch (
    input  logic                                             CLK,
    input  logic                                             nRST,
    input  logic [dispatch_pkg::WORD_W-1:0]                  imemload,
    input  logic                                             ihit,
    input  logic                                             flush,
    input  logic                                             freeze,
    input  dispatch_pkg::cu_t                                cu,
    input  dispatch_pkg::rst_entry_t [dispatch_pkg::S_REGS-1:0] s_status,
    input  dispatch_pkg::rst_entry_t [dispatch_pkg::M_REGS-1:0] m_status,
    input  logic                                             alu_busy,
    input  logic                                             ldst_busy,
    input  logic                                             br_busy,
    input  logic                                             mldst_busy,
    input  logic                                             gemm_busy,
    output logic                                             s_di_write,
    output dispatch_pkg::regbits_t                           s_di_sel,
    output dispatch_pkg::tag_t                               s_di_tag,
    output logic                                             m_di_write,
    output dispatch_pkg::matbits_t                           m_di_sel,
    output dispatch_pkg::tag_t                               m_di_tag,
    output logic                                             start_alu,
    output logic                                             start_ldst,
    output logic                                             start_br,
    output logic                                             start_mldst,
    output logic                                             start_gemm,
    output dispatch_pkg::wb_t                                start_alu_wb,
    output dispatch_pkg::wb_t                                start_ldst_wb,
    output dispatch_pkg::wb_t                                start_br_wb,
    output dispatch_pkg::wb_t                                start_mldst_wb,
    output dispatch_pkg::wb_t                                start_gemm_wb,
    output dispatch_pkg::dispatch_t                          dispatch_out,
    output logic                                             stall,
    output logic                                             fust_s_en,
    output dispatch_pkg::fu_s_t                              fu_s,
    output dispatch_pkg::fust_s_t                            fust_s,
    output logic                                             fust_m_en,
    output dispatch_pkg::fust_m_t                            fust_m,
    output logic                                             fust_g_en,
    output dispatch_pkg::fust_g_t                            fust_g
);

    dispatch_pkg::regbits_t  s_rd, s_rs1, s_rs2;
    dispatch_pkg::matbits_t  m_rd, m_rs1, m_rs2, m_rs3;
    dispatch_pkg::wb_t       s_wb, m_wb;
    dispatch_pkg::dispatch_t new_word;
    logic unit_busy;
    logic waw;
    logic hazard;
    logic flush_i;
    logic issue;

    assign s_rd  = imemload[11:7];
    assign s_rs1 = imemload[19:15];
    assign s_rs2 = imemload[24:20];
    assign m_rd  = imemload[31:28];
    assign m_rs1 = imemload[27:24];
    assign m_rs2 = imemload[23:20];
    assign m_rs3 = imemload[19:16];

    // structural hazard, the unit the instruction needs is still running
    always_comb begin
        unit_busy = 1'b0;
        case (cu.fu_t)
            dispatch_pkg::FU_S_T: begin
                case (cu.fu_s)
                    dispatch_pkg::FU_S_ALU:    unit_busy = alu_busy;
                    dispatch_pkg::FU_S_LD_ST:  unit_busy = ldst_busy;
                    dispatch_pkg::FU_S_BRANCH: unit_busy = br_busy;
                    default:                   unit_busy = 1'b0;
                endcase
            end
            dispatch_pkg::FU_M_T: unit_busy = mldst_busy;
            dispatch_pkg::FU_G_T: unit_busy = gemm_busy;
            default:              unit_busy = 1'b0;
        endcase
    end

    assign waw = cu.m_reg_write ? m_status[m_rd].busy : (cu.s_reg_write & s_status[s_rd].busy);
    assign hazard  = unit_busy | waw;
    assign stall   = ihit & hazard;
    assign flush_i = flush & ihit;
    assign issue   = ihit & ~flush & ~freeze & ~hazard;

    // status table entries are set only when the instruction actually issues
    assign s_di_write = issue & cu.s_reg_write;
    assign s_di_sel   = s_rd;
    assign s_di_tag   = (cu.fu_s == dispatch_pkg::FU_S_LD_ST) ? dispatch_pkg::TAG_LOAD
                                                               : dispatch_pkg::TAG_EXEC;
    assign m_di_write = issue & cu.m_reg_write;
    assign m_di_sel   = m_rd;
    assign m_di_tag   = (cu.fu_m == dispatch_pkg::FU_M_LD_ST) ? dispatch_pkg::TAG_LOAD
                                                               : dispatch_pkg::TAG_EXEC;

    assign fust_s_en = issue & (cu.fu_t == dispatch_pkg::FU_S_T);
    assign fust_m_en = issue & (cu.fu_t == dispatch_pkg::FU_M_T);
    assign fust_g_en = issue & (cu.fu_t == dispatch_pkg::FU_G_T);
    assign fu_s      = cu.fu_s;

    always_comb begin
        fust_s.rd  = s_rd;
        fust_s.rs1 = s_rs1;
        fust_s.rs2 = s_rs2;
        fust_s.imm = cu.imm;
        fust_s.t1  = s_status[s_rs1].tag;
        fust_s.t2  = s_status[s_rs2].tag;

        fust_m.rd  = m_rd;
        fust_m.rs1 = s_rs1;
        fust_m.rs2 = s_rs2;
        fust_m.imm = cu.imm[10:0];
        fust_m.t1  = s_status[s_rs1].tag;
        fust_m.t2  = s_status[s_rs2].tag;

        fust_g.rd  = m_rd;
        fust_g.ms1 = m_rs1;
        fust_g.ms2 = m_rs2;
        fust_g.ms3 = m_rs3;
        fust_g.t1  = m_status[m_rs1].tag;
        fust_g.t2  = m_status[m_rs2].tag;
        fust_g.t3  = m_status[m_rs3].tag;
    end

    // timer kick-off, each carries the destination it will clear
    assign s_wb = '{rw_en: cu.s_reg_write, rw: s_rd};
    assign m_wb = '{rw_en: cu.m_reg_write, rw: {1'b0, m_rd}};

    assign start_alu      = fust_s_en & (cu.fu_s == dispatch_pkg::FU_S_ALU);
    assign start_ldst     = fust_s_en & (cu.fu_s == dispatch_pkg::FU_S_LD_ST);
    assign start_br       = fust_s_en & (cu.fu_s == dispatch_pkg::FU_S_BRANCH);
    assign start_mldst    = fust_m_en;
    assign start_gemm     = fust_g_en;
    assign start_alu_wb   = s_wb;
    assign start_ldst_wb  = s_wb;
    assign start_br_wb    = s_wb;
    assign start_mldst_wb = m_wb;
    assign start_gemm_wb  = m_wb;

    always_comb begin
        new_word                   = '0;
        new_word.fu_s              = cu.fu_s;
        new_word.fu_m              = cu.fu_m;
        new_word.ex_ctr.imm        = cu.imm;
        new_word.ex_ctr.alu_op     = cu.alu_op;
        new_word.ex_ctr.branch_op  = cu.branch_op;
        new_word.ex_ctr.s_mem_type = cu.s_mem_type;
        new_word.ex_ctr.m_mem_type = cu.m_mem_type;
        new_word.ex_ctr.m_rw       = m_rd;
        new_word.ex_ctr.m_rw_en    = cu.m_reg_write;
        new_word.wb_ctr.rw_en      = cu.s_reg_write;
        new_word.wb_ctr.rw         = s_rd;
    end

    // flush wins, then hold on freeze, hazard or no valid instruction
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            dispatch_out <= '0;
        end else if (flush_i) begin
            dispatch_out <= '0;
        end else if (ihit && !freeze && !hazard) begin
            dispatch_out <= new_word;
        end
    end

endmodule

// ==== dispatch_top.sv ====
`timescale 1ns/1ps

module dispatch_top (
    input  logic                            CLK,
    input  logic                            nRST,
    input  logic [dispatch_pkg::WORD_W-1:0] imemload,
    input  logic                            ihit,
    input  logic                            flush,
    input  logic                            freeze,
    output dispatch_pkg::dispatch_t         dispatch_out,
    output logic                            fust_s_en,
    output dispatch_pkg::fu_s_t             fu_s,
    output dispatch_pkg::fust_s_t           fust_s,
    output logic                            fust_m_en,
    output dispatch_pkg::fust_m_t           fust_m,
    output logic                            fust_g_en,
    output dispatch_pkg::fust_g_t           fust_g,
    output logic                            stall
);

    dispatch_pkg::cu_t                                  cu;
    dispatch_pkg::rst_entry_t [dispatch_pkg::S_REGS-1:0] s_status;
    dispatch_pkg::rst_entry_t [dispatch_pkg::M_REGS-1:0] m_status;
    dispatch_pkg::regbits_t s_di_sel;
    dispatch_pkg::matbits_t m_di_sel;
    dispatch_pkg::tag_t     s_di_tag, m_di_tag;
    logic s_di_write, m_di_write;
    logic alu_busy, ldst_busy, br_busy, mldst_busy, gemm_busy;
    logic start_alu, start_ldst, start_br, start_mldst, start_gemm;
    dispatch_pkg::wb_t start_alu_wb, start_ldst_wb, start_br_wb;
    dispatch_pkg::wb_t start_mldst_wb, start_gemm_wb;
    dispatch_pkg::wb_t alu_wb, ldst_wb, mldst_wb, gemm_wb;

    control_unit u_control_unit (.instr(imemload), .cu(cu));

    dispatch u_dispatch (.*);

    // scalar results come back from the ALU and load/store timers
    reg_status_table #(.NREGS(dispatch_pkg::S_REGS)) u_s_rst (
        .CLK(CLK), .nRST(nRST), .di_write(s_di_write), .di_sel(s_di_sel),
        .di_tag(s_di_tag), .wb_a(alu_wb), .wb_b(ldst_wb), .status(s_status)
    );

    reg_status_table #(.NREGS(dispatch_pkg::M_REGS)) u_m_rst (
        .CLK(CLK), .nRST(nRST), .di_write(m_di_write), .di_sel(m_di_sel),
        .di_tag(m_di_tag), .wb_a(mldst_wb), .wb_b(gemm_wb), .status(m_status)
    );

    fu_timer #(.LATENCY(dispatch_pkg::LAT_ALU)) u_alu_timer (
        .CLK(CLK), .nRST(nRST), .start(start_alu), .start_wb(start_alu_wb),
        .busy(alu_busy), .wb(alu_wb)
    );

    fu_timer #(.LATENCY(dispatch_pkg::LAT_LDST)) u_ldst_timer (
        .CLK(CLK), .nRST(nRST), .start(start_ldst), .start_wb(start_ldst_wb),
        .busy(ldst_busy), .wb(ldst_wb)
    );

    // branches write no register, so their writeback goes nowhere
    fu_timer #(.LATENCY(dispatch_pkg::LAT_BRANCH)) u_br_timer (
        .CLK(CLK), .nRST(nRST), .start(start_br), .start_wb(start_br_wb),
        .busy(br_busy), .wb()
    );

    fu_timer #(.LATENCY(dispatch_pkg::LAT_MLDST)) u_mldst_timer (
        .CLK(CLK), .nRST(nRST), .start(start_mldst), .start_wb(start_mldst_wb),
        .busy(mldst_busy), .wb(mldst_wb)
    );

    fu_timer #(.LATENCY(dispatch_pkg::LAT_GEMM)) u_gemm_timer (
        .CLK(CLK), .nRST(nRST), .start(start_gemm), .start_wb(start_gemm_wb),
        .busy(gemm_busy), .wb(gemm_wb)
    );

endmodule

// ==== tb_dispatch.sv ====
`timescale 1ns/1ps

module tb_dispatch;

    localparam int MAX_CYCLES = 400;

    logic                            CLK;
    logic                            nRST;
    logic [dispatch_pkg::WORD_W-1:0] imemload;
    logic                            ihit;
    logic                            flush;
    logic                            freeze;
    dispatch_pkg::dispatch_t         dispatch_out;
    logic                            fust_s_en;
    dispatch_pkg::fu_s_t             fu_s;
    dispatch_pkg::fust_s_t           fust_s;
    logic                            fust_m_en;
    dispatch_pkg::fust_m_t           fust_m;
    logic                            fust_g_en;
    dispatch_pkg::fust_g_t           fust_g;
    logic                            stall;

    int errors = 0;
    int checks = 0;
    int cycles = 0;

    dispatch_top uut (
        .CLK(CLK), .nRST(nRST), .imemload(imemload), .ihit(ihit), .flush(flush),
        .freeze(freeze), .dispatch_out(dispatch_out), .fust_s_en(fust_s_en), .fu_s(fu_s),
        .fust_s(fust_s), .fust_m_en(fust_m_en), .fust_m(fust_m), .fust_g_en(fust_g_en),
        .fust_g(fust_g), .stall(stall)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // watchdog on the total run length
    always @(posedge CLK) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_cycles(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("[FAIL] %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_fu_s(input string name, input dispatch_pkg::fu_s_t exp,
                              input dispatch_pkg::fu_s_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_dispatch(input string name, input dispatch_pkg::dispatch_t exp,
                                  input dispatch_pkg::dispatch_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_fust_s(input string name, input dispatch_pkg::fust_s_t exp,
                                input dispatch_pkg::fust_s_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_fust_m(input string name, input dispatch_pkg::fust_m_t exp,
                                input dispatch_pkg::fust_m_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_fust_g(input string name, input dispatch_pkg::fust_g_t exp,
                                input dispatch_pkg::fust_g_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %h got %h", name, exp, act);
        end
    endtask

    // scalar format with funct3 and funct7 left at zero
    function automatic logic [31:0] s_instr(input dispatch_pkg::opcode_t op,
                                            input dispatch_pkg::regbits_t rd,
                                            input dispatch_pkg::regbits_t rs1,
                                            input dispatch_pkg::regbits_t rs2);
        return {7'b0, rs2, rs1, 3'b000, rd, op};
    endfunction

    function automatic logic [31:0] m_instr(input dispatch_pkg::opcode_t op,
                                            input dispatch_pkg::matbits_t rd,
                                            input dispatch_pkg::matbits_t ms1,
                                            input dispatch_pkg::matbits_t ms2,
                                            input dispatch_pkg::matbits_t ms3);
        return {rd, ms1, ms2, ms3, 9'b0, op};
    endfunction

    // expected control word of a scalar op with zero immediate
    function automatic dispatch_pkg::dispatch_t scalar_word(input dispatch_pkg::fu_s_t fu,
                                                            input dispatch_pkg::mem_type_t mem,
                                                            input dispatch_pkg::regbits_t rd);
        dispatch_pkg::dispatch_t w;
        w                   = '0;
        w.fu_s              = fu;
        w.ex_ctr.s_mem_type = mem;
        w.wb_ctr.rw_en      = 1'b1;
        w.wb_ctr.rw         = rd;
        return w;
    endfunction

    function automatic dispatch_pkg::dispatch_t gemm_word(input dispatch_pkg::matbits_t rd);
        dispatch_pkg::dispatch_t w;
        w                = '0;
        w.fu_m           = dispatch_pkg::FU_M_GEMM;
        w.ex_ctr.m_rw    = rd;
        w.ex_ctr.m_rw_en = 1'b1;
        return w;
    endfunction

    task automatic next_cycle();
        @(posedge CLK);
        #2;
    endtask

    // outputs are sampled 1 ns after the inputs settle
    task automatic present(input logic [31:0] instr, input logic fl, input logic fz);
        next_cycle();
        imemload = instr;
        ihit     = 1'b1;
        flush    = fl;
        freeze   = fz;
        #1;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            next_cycle();
            ihit   = 1'b0;
            flush  = 1'b0;
            freeze = 1'b0;
        end
        #1;
    endtask

    task automatic no_enables();
        check_bit("fust_s_en", 1'b0, fust_s_en);
        check_bit("fust_m_en", 1'b0, fust_m_en);
        check_bit("fust_g_en", 1'b0, fust_g_en);
    endtask

    // keeps the presented instruction until an enable rises
    task automatic hold_until_issue(input dispatch_pkg::dispatch_t held, input int exp_cycles);
        int n;
        n = 0;
        while (!(fust_s_en || fust_m_en || fust_g_en)) begin
            check_bit("stall", 1'b1, stall);
            check_dispatch("dispatch_out", held, dispatch_out);
            next_cycle();
            #1;
            n++;
        end
        check_cycles("stall cycles", exp_cycles, n);
        check_bit("stall", 1'b0, stall);
    endtask

    task automatic reset_values();
        repeat (16) @(posedge CLK);
        #3;
        check_dispatch("dispatch_out", '0, dispatch_out);
        no_enables();
        check_bit("stall", 1'b0, stall);
        next_cycle();
        nRST = 1'b1;
        idle(1);
        check_dispatch("dispatch_out", '0, dispatch_out);
        no_enables();
        check_bit("stall", 1'b0, stall);
    endtask

    task automatic scalar_issue();
        present(s_instr(dispatch_pkg::OP_ALU, 5'd4, 5'd1, 5'd2), 1'b0, 1'b0);
        check_bit("fust_s_en", 1'b1, fust_s_en);
        check_fu_s("fu_s", dispatch_pkg::FU_S_ALU, fu_s);
        check_fust_s("fust_s", '{rd: 5'd4, rs1: 5'd1, rs2: 5'd2, imm: 12'd0,
                     t1: dispatch_pkg::TAG_NONE, t2: dispatch_pkg::TAG_NONE}, fust_s);
        idle(1);
        check_dispatch("dispatch_out",
                       scalar_word(dispatch_pkg::FU_S_ALU, dispatch_pkg::NONE, 5'd4),
                       dispatch_out);
        idle(2);
    endtask

    task automatic tag_and_waw();
        present(s_instr(dispatch_pkg::OP_LOAD, 5'd5, 5'd0, 5'd0), 1'b0, 1'b0);
        check_bit("fust_s_en", 1'b1, fust_s_en);
        // x5 now waits on the load unit
        present(s_instr(dispatch_pkg::OP_ALU, 5'd6, 5'd5, 5'd0), 1'b0, 1'b0);
        check_bit("fust_s_en", 1'b1, fust_s_en);
        check_fust_s("fust_s", '{rd: 5'd6, rs1: 5'd5, rs2: 5'd0, imm: 12'd0,
                     t1: dispatch_pkg::TAG_LOAD, t2: dispatch_pkg::TAG_NONE}, fust_s);
        // presented one cycle after the first load issued
        present(s_instr(dispatch_pkg::OP_LOAD, 5'd5, 5'd0, 5'd0), 1'b0, 1'b0);
        hold_until_issue(scalar_word(dispatch_pkg::FU_S_ALU, dispatch_pkg::NONE, 5'd6),
                         dispatch_pkg::LAT_LDST - 1);
        check_bit("fust_s_en", 1'b1, fust_s_en);
        // the ALU is free here and only the pending x5 holds this back
        present(s_instr(dispatch_pkg::OP_ALU, 5'd5, 5'd0, 5'd0), 1'b0, 1'b0);
        hold_until_issue(scalar_word(dispatch_pkg::FU_S_LD_ST, dispatch_pkg::LOAD, 5'd5),
                         dispatch_pkg::LAT_LDST);
        check_bit("fust_s_en", 1'b1, fust_s_en);
        idle(4);
    endtask

    task automatic structural_hazard();
        present(m_instr(dispatch_pkg::OP_GEMM, 4'd1, 4'd2, 4'd3, 4'd4), 1'b0, 1'b0);
        check_bit("fust_g_en", 1'b1, fust_g_en);
        check_fust_g("fust_g", '{rd: 4'd1, ms1: 4'd2, ms2: 4'd3, ms3: 4'd4,
                     t1: dispatch_pkg::TAG_NONE, t2: dispatch_pkg::TAG_NONE,
                     t3: dispatch_pkg::TAG_NONE}, fust_g);
        present(m_instr(dispatch_pkg::OP_GEMM, 4'd5, 4'd6, 4'd7, 4'd8), 1'b0, 1'b0);
        hold_until_issue(gemm_word(4'd1), dispatch_pkg::LAT_GEMM);
        check_bit("fust_g_en", 1'b1, fust_g_en);
        check_fust_g("fust_g", '{rd: 4'd5, ms1: 4'd6, ms2: 4'd7, ms3: 4'd8,
                     t1: dispatch_pkg::TAG_NONE, t2: dispatch_pkg::TAG_NONE,
                     t3: dispatch_pkg::TAG_NONE}, fust_g);
        idle(dispatch_pkg::LAT_GEMM + 2);
    endtask

    task automatic matrix_path();
        present(m_instr(dispatch_pkg::OP_MLOAD, 4'd3, 4'd0, 4'd0, 4'd0), 1'b0, 1'b0);
        check_bit("fust_m_en", 1'b1, fust_m_en);
        check_fust_m("fust_m", '{rd: 4'd3, rs1: 5'd0, rs2: 5'd0, imm: 11'd0,
                     t1: dispatch_pkg::TAG_NONE, t2: dispatch_pkg::TAG_NONE}, fust_m);
        // m3 is still pending on the matrix load
        present(m_instr(dispatch_pkg::OP_GEMM, 4'd7, 4'd3, 4'd4, 4'd5), 1'b0, 1'b0);
        check_bit("fust_g_en", 1'b1, fust_g_en);
        check_fust_g("fust_g", '{rd: 4'd7, ms1: 4'd3, ms2: 4'd4, ms3: 4'd5,
                     t1: dispatch_pkg::TAG_LOAD, t2: dispatch_pkg::TAG_NONE,
                     t3: dispatch_pkg::TAG_NONE}, fust_g);
        idle(dispatch_pkg::LAT_GEMM + 2);
    endtask

    task automatic flush_and_freeze();
        present(s_instr(dispatch_pkg::OP_ALU, 5'd9, 5'd1, 5'd2), 1'b0, 1'b0);
        check_bit("fust_s_en", 1'b1, fust_s_en);
        // the load unit is idle here and only the flush blocks the issue
        present(s_instr(dispatch_pkg::OP_LOAD, 5'd8, 5'd0, 5'd0), 1'b1, 1'b0);
        no_enables();
        idle(1);
        check_dispatch("dispatch_out", '0, dispatch_out);
        present(s_instr(dispatch_pkg::OP_LOAD, 5'd10, 5'd0, 5'd0), 1'b0, 1'b0);
        check_bit("fust_s_en", 1'b1, fust_s_en);
        present(s_instr(dispatch_pkg::OP_ALU, 5'd12, 5'd1, 5'd2), 1'b0, 1'b1);
        no_enables();
        check_bit("stall", 1'b0, stall);
        // x12 is still free because the frozen cycle set no table entry
        present(s_instr(dispatch_pkg::OP_ALU, 5'd12, 5'd1, 5'd2), 1'b0, 1'b0);
        check_dispatch("dispatch_out",
                       scalar_word(dispatch_pkg::FU_S_LD_ST, dispatch_pkg::LOAD, 5'd10),
                       dispatch_out);
        check_bit("fust_s_en", 1'b1, fust_s_en);
        check_bit("stall", 1'b0, stall);
        idle(3);
    endtask

    initial begin
        nRST     = 1'b0;
        imemload = '0;
        ihit     = 1'b0;
        flush    = 1'b0;
        freeze   = 1'b0;
        reset_values();
        scalar_issue();
        tag_and_waw();
        structural_hazard();
        matrix_path();
        flush_and_freeze();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
dispatch_pkg.sv
control_unit.sv
reg_status_table.sv
fu_timer.sv
dispatch.sv
dispatch_top.sv
tb_dispatch.sv
